// File: Bender.yml
package:
  name: mem_pipe

sources:
  - design/MemPipeTypes.sv
  - design/MemStageIF.sv
  - design/StageLatch.sv
  - design/RegisterFile.sv
  - design/MemRegReadStage.sv
  - design/MemExecStage.sv
  - design/MemResultStage.sv
  - design/MemPipeTop.sv
  - target: test
    files:
      - test/MemPipe_assertions.sv
      - test/MemPipeTb.sv

// File: design/MemExecStage.sv
//******************************
// Address generation for the memory lane.
// An op with any operand not ready becomes a one-cycle replay to the issue
// queue and is not passed on. The replay waits while stall is high.
//******************************
`timescale 1ns/100ps

module MemExecStage (
    MemStageIF.stage exIn,
    input logic stall,
    output logic resValid,
    output MemPipeTypes::MemResultPayload resPayload,
    output logic replayValid,
    output MemPipeTypes::IssueQueuePtr replayPtr
);
    import MemPipeTypes::*;

    MemExecPayload item;
    logic live;
    logic operandsReady;

    assign item = exIn.payload;
    assign live = exIn.valid && !(exIn.flush && exIn.kill);
    assign operandsReady = item.operandA.ready && item.operandB.ready;

    // Effective address is base plus offset
    always_comb begin
        resPayload.opType = item.opType;
        resPayload.dstReg = item.dstReg;
        resPayload.writeReg = item.writeReg;
        resPayload.activeListPtr = item.activeListPtr;
        resPayload.addr = item.operandA.data + signExtImm(item.imm);
        resPayload.storeData = item.operandB.data;
    end

    assign resValid = live && operandsReady;

    // Frees the issue-queue entry for a later reissue
    assign replayValid = live && !operandsReady && !stall;
    assign replayPtr = item.issueQueuePtr;

endmodule

// File: design/MemPipeTop.sv
//******************************
// Memory lane back end from issue to writeback, three edges without stall.
// Issued ops are always accepted; stall and clear apply to every latch.
//******************************
`timescale 1ns/100ps

module MemPipeTop (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic flushValid,
    input MemPipeTypes::ActiveListPtr flushHead,
    input MemPipeTypes::ActiveListPtr flushTail,
    input logic issueValid,
    input logic issueOpType,
    input logic [1:0] issueOperandTypeA,
    input logic [1:0] issueOperandTypeB,
    input MemPipeTypes::PRegNum issueSrcRegA,
    input MemPipeTypes::PRegNum issueSrcRegB,
    input MemPipeTypes::PRegNum issueDstReg,
    input logic issueWriteReg,
    input logic [MemPipeTypes::IMM_WIDTH-1:0] issueImm,
    input logic [MemPipeTypes::DATA_WIDTH-1:0] issuePc,
    input MemPipeTypes::ActiveListPtr issueActiveListPtr,
    input MemPipeTypes::IssueQueuePtr issueIssueQueuePtr,
    input logic issueHasMshr,
    input MemPipeTypes::MshrId issueMshrId,
    input logic allocValid,
    input MemPipeTypes::PRegNum allocReg,
    output logic wbValid,
    output MemPipeTypes::PRegNum wbReg,
    output logic [MemPipeTypes::DATA_WIDTH-1:0] wbData,
    output logic replayValid,
    output MemPipeTypes::IssueQueuePtr replayPtr,
    output logic mshrRelease,
    output MemPipeTypes::MshrId mshrReleaseId
);
    import MemPipeTypes::*;

    MemIssuePayload issuePayload;
    MemExecPayload execPayload;
    MemResultPayload resPayload;
    logic execValid;
    logic resValid;
    PRegNum regA;
    PRegNum regB;
    logic [DATA_WIDTH-1:0] dataA;
    logic [DATA_WIDTH-1:0] dataB;
    logic readyA;
    logic readyB;

    MemStageIF #(.Payload(MemIssuePayload)) rrIf ();
    MemStageIF #(.Payload(MemExecPayload)) exIf ();
    MemStageIF #(.Payload(MemResultPayload)) resIf ();

    assign issuePayload = '{
        opType: MemOpType'(issueOpType),
        operandTypeA: OperandType'(issueOperandTypeA),
        operandTypeB: OperandType'(issueOperandTypeB),
        srcRegA: issueSrcRegA,
        srcRegB: issueSrcRegB,
        dstReg: issueDstReg,
        writeReg: issueWriteReg,
        imm: issueImm,
        pc: issuePc,
        activeListPtr: issueActiveListPtr,
        issueQueuePtr: issueIssueQueuePtr,
        hasMshr: issueHasMshr,
        mshrId: issueMshrId
    };

    StageLatch #(.Payload(MemIssuePayload)) rrLatch (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear),
        .flushValid(flushValid), .flushHead(flushHead), .flushTail(flushTail),
        .inValid(issueValid), .inPayload(issuePayload), .stageOut(rrIf.latch)
    );

    RegisterFile regFile (
        .clk(clk), .rstN(rstN),
        .readRegA(regA), .readRegB(regB),
        .readDataA(dataA), .readDataB(dataB),
        .readReadyA(readyA), .readReadyB(readyB),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .allocValid(allocValid), .allocReg(allocReg)
    );

    MemRegReadStage rrStage (
        .rrIn(rrIf.stage),
        .regA(regA), .regB(regB), .dataA(dataA), .dataB(dataB),
        .readyA(readyA), .readyB(readyB),
        .execValid(execValid), .execPayload(execPayload),
        .mshrRelease(mshrRelease), .mshrReleaseId(mshrReleaseId)
    );

    StageLatch #(.Payload(MemExecPayload)) exLatch (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear),
        .flushValid(flushValid), .flushHead(flushHead), .flushTail(flushTail),
        .inValid(execValid), .inPayload(execPayload), .stageOut(exIf.latch)
    );

    MemExecStage exStage (
        .exIn(exIf.stage), .stall(stall),
        .resValid(resValid), .resPayload(resPayload),
        .replayValid(replayValid), .replayPtr(replayPtr)
    );

    StageLatch #(.Payload(MemResultPayload)) resLatch (
        .clk(clk), .rstN(rstN), .stall(stall), .clear(clear),
        .flushValid(flushValid), .flushHead(flushHead), .flushTail(flushTail),
        .inValid(resValid), .inPayload(resPayload), .stageOut(resIf.latch)
    );

    MemResultStage resStage (
        .clk(clk), .rstN(rstN), .stall(stall), .resIn(resIf.stage),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
    );

endmodule

// File: design/MemPipeTypes.sv
//******************************
// Shared widths, encodings and stage payloads of the single-lane memory pipeline.
// Pointer and index widths follow from the entry counts below.
// Immediates are 12 bits and are always sign-extended before use.
//******************************
package MemPipeTypes;

    localparam int DATA_WIDTH = 32;
    localparam int PREG_NUM = 32;
    localparam int ACTIVE_LIST_NUM = 16;
    localparam int ISSUE_QUEUE_NUM = 8;
    localparam int MSHR_NUM = 4;
    localparam int DMEM_WORDS = 64;
    localparam int IMM_WIDTH = 12;
    localparam int DMEM_INDEX_WIDTH = $clog2(DMEM_WORDS);

    typedef logic [$clog2(PREG_NUM)-1:0] PRegNum;
    typedef logic [$clog2(ACTIVE_LIST_NUM)-1:0] ActiveListPtr;
    typedef logic [$clog2(ISSUE_QUEUE_NUM)-1:0] IssueQueuePtr;
    typedef logic [$clog2(MSHR_NUM)-1:0] MshrId;

    // Operand source
    typedef enum logic [1:0] {
        OPERAND_REG = 2'd0,
        OPERAND_IMM = 2'd1,
        OPERAND_PC = 2'd2
    } OperandType;

    typedef enum logic {
        MEM_LOAD = 1'b0,
        MEM_STORE = 1'b1
    } MemOpType;

    // Operand value with its ready flag
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic ready;
    } OperandValue;

    // Item held in front of register read
    typedef struct packed {
        MemOpType opType;
        OperandType operandTypeA;
        OperandType operandTypeB;
        PRegNum srcRegA;
        PRegNum srcRegB;
        PRegNum dstReg;
        logic writeReg;
        logic [IMM_WIDTH-1:0] imm;
        logic [DATA_WIDTH-1:0] pc;
        ActiveListPtr activeListPtr;
        IssueQueuePtr issueQueuePtr;
        logic hasMshr;
        MshrId mshrId;
    } MemIssuePayload;

    // Item held in front of execute
    typedef struct packed {
        MemOpType opType;
        PRegNum dstReg;
        logic writeReg;
        logic [IMM_WIDTH-1:0] imm;
        ActiveListPtr activeListPtr;
        IssueQueuePtr issueQueuePtr;
        OperandValue operandA;
        OperandValue operandB;
    } MemExecPayload;

    // Item held in front of the memory access
    typedef struct packed {
        MemOpType opType;
        PRegNum dstReg;
        logic writeReg;
        ActiveListPtr activeListPtr;
        logic [DATA_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] storeData;
    } MemResultPayload;

    function automatic logic [DATA_WIDTH-1:0] signExtImm(input logic [IMM_WIDTH-1:0] imm);
        return {{(DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    endfunction

endpackage

// File: design/MemRegReadStage.sv
//******************************
// Register read for the memory lane.
// Immediate and PC operands are always ready. A flushed load that owns a
// miss-status entry releases it for exactly the cycle it is seen flushed.
//******************************
`timescale 1ns/100ps

module MemRegReadStage (
    MemStageIF.stage rrIn,
    output MemPipeTypes::PRegNum regA,
    output MemPipeTypes::PRegNum regB,
    input logic [MemPipeTypes::DATA_WIDTH-1:0] dataA,
    input logic [MemPipeTypes::DATA_WIDTH-1:0] dataB,
    input logic readyA,
    input logic readyB,
    output logic execValid,
    output MemPipeTypes::MemExecPayload execPayload,
    output logic mshrRelease,
    output MemPipeTypes::MshrId mshrReleaseId
);
    import MemPipeTypes::*;

    MemIssuePayload item;
    logic flushed;

    function automatic OperandValue selectOperand(
        input OperandType operandType,
        input logic [DATA_WIDTH-1:0] regValue,
        input logic regReady,
        input logic [IMM_WIDTH-1:0] imm,
        input logic [DATA_WIDTH-1:0] pc
    );
        OperandValue operand;

        case (operandType)
            OPERAND_IMM: begin
                operand.data = signExtImm(imm);
                operand.ready = 1'b1;
            end
            OPERAND_PC: begin
                operand.data = pc;
                operand.ready = 1'b1;
            end
            default: begin
                operand.data = regValue;
                operand.ready = regReady;
            end
        endcase
        return operand;
    endfunction

    assign item = rrIn.payload;
    assign flushed = rrIn.flush && rrIn.kill;

    assign regA = item.srcRegA;
    assign regB = item.srcRegB;

    always_comb begin
        execPayload.opType = item.opType;
        execPayload.dstReg = item.dstReg;
        execPayload.writeReg = item.writeReg;
        execPayload.imm = item.imm;
        execPayload.activeListPtr = item.activeListPtr;
        execPayload.issueQueuePtr = item.issueQueuePtr;
        execPayload.operandA = selectOperand(item.operandTypeA, dataA, readyA, item.imm, item.pc);
        execPayload.operandB = selectOperand(item.operandTypeB, dataB, readyB, item.imm, item.pc);
    end

    // Flushed items never reach the execute latch
    assign execValid = rrIn.valid && !flushed;

    assign mshrRelease = rrIn.valid && flushed && (item.opType == MEM_LOAD) && item.hasMshr;
    assign mshrReleaseId = item.mshrId;

endmodule

// File: design/MemResultStage.sv
//******************************
// Word-addressed local data memory and load writeback.
// Address bits 7..2 select the word; other address bits are ignored.
// Nothing is written and no writeback is shown while stall is high.
//******************************
`timescale 1ns/100ps

module MemResultStage (
    input logic clk,
    input logic rstN,
    input logic stall,
    MemStageIF.stage resIn,
    output logic wbValid,
    output MemPipeTypes::PRegNum wbReg,
    output logic [MemPipeTypes::DATA_WIDTH-1:0] wbData
);
    import MemPipeTypes::*;

    logic [DATA_WIDTH-1:0] dmem [DMEM_WORDS];
    MemResultPayload item;
    logic [DMEM_INDEX_WIDTH-1:0] wordIndex;
    logic live;
    logic storeEn;

    assign item = resIn.payload;
    assign wordIndex = item.addr[DMEM_INDEX_WIDTH+1:2];
    assign live = resIn.valid && !(resIn.flush && resIn.kill) && !stall;
    assign storeEn = live && (item.opType == MEM_STORE);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (storeEn) begin
            dmem[wordIndex] <= item.storeData;
        end
    end

    // Load data comes straight out of the array
    assign wbValid = live && (item.opType == MEM_LOAD) && item.writeReg;
    assign wbReg = item.dstReg;
    assign wbData = dmem[wordIndex];

endmodule

// File: design/MemStageIF.sv
//******************************
// One latched pipeline item on its way to the consuming stage.
// kill is the flush range test of the held item, flush says that range is live.
//******************************
`timescale 1ns/100ps

interface MemStageIF #(
    parameter type Payload = logic
);

    logic valid;
    Payload payload;
    // Flush range is live this cycle
    logic flush;
    // Held item lies inside the flush range
    logic kill;

    modport latch (
        output valid,
        output payload,
        output flush,
        output kill
    );

    modport stage (
        input valid,
        input payload,
        input flush,
        input kill
    );

endinterface

// File: design/RegisterFile.sv
//******************************
// Physical registers with ready bits, two read ports and one write port.
// Reads forward a same-cycle writeback. Writeback beats allocation.
//******************************
`timescale 1ns/100ps

module RegisterFile (
    input logic clk,
    input logic rstN,
    input MemPipeTypes::PRegNum readRegA,
    input MemPipeTypes::PRegNum readRegB,
    output logic [MemPipeTypes::DATA_WIDTH-1:0] readDataA,
    output logic [MemPipeTypes::DATA_WIDTH-1:0] readDataB,
    output logic readReadyA,
    output logic readReadyB,
    input logic wbValid,
    input MemPipeTypes::PRegNum wbReg,
    input logic [MemPipeTypes::DATA_WIDTH-1:0] wbData,
    input logic allocValid,
    input MemPipeTypes::PRegNum allocReg
);
    import MemPipeTypes::*;

    logic [DATA_WIDTH-1:0] regData [PREG_NUM];
    logic [PREG_NUM-1:0] regReady;
    logic forwardA;
    logic forwardB;

    // Write-through on a matching writeback
    assign forwardA = wbValid && (wbReg == readRegA);
    assign forwardB = wbValid && (wbReg == readRegB);

    assign readDataA = forwardA ? wbData : regData[readRegA];
    assign readDataB = forwardB ? wbData : regData[readRegB];
    assign readReadyA = forwardA || regReady[readRegA];
    assign readReadyB = forwardB || regReady[readRegB];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regData[i] <= '0;
            end
            regReady <= '1;
        end else begin
            if (allocValid) begin
                regReady[allocReg] <= 1'b0;
            end
            // Later assignment wins on the same register
            if (wbValid) begin
                regReady[wbReg] <= 1'b1;
                regData[wbReg] <= wbData;
            end
        end
    end

endmodule

// File: design/StageLatch.sv
//******************************
// Single-entry pipeline register for any payload with an activeListPtr field.
// Priority is reset or clear, then stall, then load. The flush range is
// circular, head inclusive, tail exclusive; equal pointers cover the whole list.
//******************************
`timescale 1ns/100ps

module StageLatch #(
    parameter type Payload = MemPipeTypes::MemIssuePayload
) (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic flushValid,
    input MemPipeTypes::ActiveListPtr flushHead,
    input MemPipeTypes::ActiveListPtr flushTail,
    input logic inValid,
    input Payload inPayload,
    MemStageIF.latch stageOut
);
    import MemPipeTypes::*;

    logic validReg;
    Payload payloadReg;
    logic inRange;

    function automatic logic inFlushRange(
        input ActiveListPtr ptr,
        input ActiveListPtr head,
        input ActiveListPtr tail
    );
        if (head == tail) begin
            return 1'b1;
        end else if (head < tail) begin
            return (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the last entry
            return (ptr >= head) || (ptr < tail);
        end
    endfunction

    assign inRange = inFlushRange(payloadReg.activeListPtr, flushHead, flushTail);

    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            validReg <= 1'b0;
        end else if (stall) begin
            // Held item still dies if it gets flushed
            if (flushValid && inRange) begin
                validReg <= 1'b0;
            end
        end else begin
            validReg <= inValid;
            payloadReg <= inPayload;
        end
    end

    assign stageOut.valid = validReg;
    assign stageOut.payload = payloadReg;
    assign stageOut.flush = flushValid;
    assign stageOut.kill = inRange;

endmodule

// File: files.f
design/MemPipeTypes.sv
design/MemStageIF.sv
design/StageLatch.sv
design/RegisterFile.sv
design/MemRegReadStage.sv
design/MemExecStage.sv
design/MemResultStage.sv
design/MemPipeTop.sv
test/MemPipe_assertions.sv
test/MemPipeTb.sv

// File: test/MemPipeTb.sv
//******************************
// Testbench for the memory lane, driven from test/mem_stimulus.txt.
// One data line per cycle; inputs go 1 ns after the rising edge and the
// expected outputs of that line are sampled on the falling edge.
//******************************
`timescale 1ns/100ps

module MemPipeTb;
    import MemPipeTypes::*;

    localparam int RESET_CYCLES = 4;
    localparam int STIMULUS_LINES = 39;
    localparam int FIELD_NUM = 28;
    localparam int CYCLE_LIMIT = STIMULUS_LINES + 20;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    logic flushValid;
    ActiveListPtr flushHead;
    ActiveListPtr flushTail;
    logic issueValid;
    logic issueOpType;
    logic [1:0] issueOperandTypeA;
    logic [1:0] issueOperandTypeB;
    PRegNum issueSrcRegA;
    PRegNum issueSrcRegB;
    PRegNum issueDstReg;
    logic issueWriteReg;
    logic [IMM_WIDTH-1:0] issueImm;
    logic [DATA_WIDTH-1:0] issuePc;
    ActiveListPtr issueActiveListPtr;
    IssueQueuePtr issueIssueQueuePtr;
    logic issueHasMshr;
    MshrId issueMshrId;
    logic allocValid;
    PRegNum allocReg;
    logic wbValid;
    PRegNum wbReg;
    logic [DATA_WIDTH-1:0] wbData;
    logic replayValid;
    IssueQueuePtr replayPtr;
    logic mshrRelease;
    MshrId mshrReleaseId;

    logic [31:0] field [FIELD_NUM];
    int errorCount;
    int checkCount;
    int cycleCount;
    int linesRead;

    MemPipeTop dut0 (.*);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic reportAndFinish();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Reads the next data line and skips blanks and comment lines
    task automatic readStimulusLine(input int fd, output bit got, output bit wellFormed);
        string line;
        int count;

        got = 1'b0;
        wellFormed = 1'b0;
        while (!got && !$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (count > 0 && line.len() > 1 && line[0] != 8'h23) begin
                got = 1'b1;
                count = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    field[0], field[1], field[2], field[3], field[4], field[5], field[6],
                    field[7], field[8], field[9], field[10], field[11], field[12], field[13],
                    field[14], field[15], field[16], field[17], field[18], field[19],
                    field[20], field[21], field[22], field[23], field[24], field[25],
                    field[26], field[27]);
                wellFormed = (count == FIELD_NUM);
            end
        end
    endtask

    task automatic driveInputs();
        stall = field[0][0];
        clear = field[1][0];
        flushValid = field[2][0];
        flushHead = ActiveListPtr'(field[3]);
        flushTail = ActiveListPtr'(field[4]);
        issueValid = field[5][0];
        issueOpType = field[6][0];
        issueOperandTypeA = field[7][1:0];
        issueOperandTypeB = field[8][1:0];
        issueSrcRegA = PRegNum'(field[9]);
        issueSrcRegB = PRegNum'(field[10]);
        issueDstReg = PRegNum'(field[11]);
        issueWriteReg = field[12][0];
        issueImm = field[13][IMM_WIDTH-1:0];
        issuePc = field[14];
        issueActiveListPtr = ActiveListPtr'(field[15]);
        issueIssueQueuePtr = IssueQueuePtr'(field[16]);
        issueHasMshr = field[17][0];
        issueMshrId = MshrId'(field[18]);
        allocValid = field[19][0];
        allocReg = PRegNum'(field[20]);
    endtask

    // Payload outputs only matter when their valid is expected high
    task automatic checkOutputs();
        checkValue("wbValid", field[21], 32'(wbValid));
        if (field[21][0]) begin
            checkValue("wbReg", field[22], 32'(wbReg));
            checkValue("wbData", field[23], wbData);
        end
        checkValue("replayValid", field[24], 32'(replayValid));
        if (field[24][0]) begin
            checkValue("replayPtr", field[25], 32'(replayPtr));
        end
        checkValue("mshrRelease", field[26], 32'(mshrRelease));
        if (field[26][0]) begin
            checkValue("mshrReleaseId", field[27], 32'(mshrReleaseId));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycleCount);
            errorCount++;
            reportAndFinish();
        end
    end

    initial begin
        int fd;
        bit got;
        bit wellFormed;
        bit done;

        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        linesRead = 0;
        done = 1'b0;
        rstN = 1'b0;
        for (int i = 0; i < FIELD_NUM; i++) begin
            field[i] = '0;
        end
        driveInputs();

        fd = $fopen("test/mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/mem_stimulus.txt");
            errorCount++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            while (!done) begin
                readStimulusLine(fd, got, wellFormed);
                if (!got) begin
                    done = 1'b1;
                end else if (!wellFormed) begin
                    $display("Stimulus line %0d does not hold %0d fields",
                             linesRead + 1, FIELD_NUM);
                    errorCount++;
                    done = 1'b1;
                end else begin
                    #1;
                    rstN = 1'b1;
                    driveInputs();
                    @(negedge clk);
                    checkOutputs();
                    linesRead++;
                    @(posedge clk);
                end
            end
            $fclose(fd);

            if (linesRead != STIMULUS_LINES) begin
                $display("Stimulus file ended after %0d of %0d lines",
                         linesRead, STIMULUS_LINES);
                errorCount++;
            end
        end
        reportAndFinish();
    end

endmodule

// File: test/MemPipe_assertions.sv
//******************************
// Concurrent checks on the memory lane outputs, bound to MemPipeTop.
// The release check assumes a held item flushed under stall is gone next cycle.
//******************************
`timescale 1ns/100ps

module MemPipeAssertions (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic wbValid,
    input logic replayValid,
    input logic mshrRelease
);

    // Quiet while reset has been held for a full cycle
    assert property (@(posedge clk) (!rstN && $past(!rstN)) |-> (!wbValid && !replayValid))
        else $error("wbValid or replayValid high during reset");

    assert property (@(posedge clk) disable iff (!rstN) stall |-> (!wbValid && !replayValid))
        else $error("wbValid or replayValid high during stall");

    assert property (@(posedge clk) disable iff (!rstN) !(wbValid && replayValid))
        else $error("wbValid and replayValid high together");

    assert property (@(posedge clk) disable iff (!rstN) (mshrRelease && stall) |=> !mshrRelease)
        else $error("mshrRelease repeated for a held item");

endmodule

bind MemPipeTop MemPipeAssertions memPipeChecks (.*);

// File: test/mem_stimulus.txt
# st cl fv fh ft iv op oA oB sA sB dst wr imm pc alp iqp hm mid av ar
#   then expected: wb wbReg wbData rp rpPtr mshr mshrId (all hex)
0 0 0 0 0 1 1 0 1 00 00 00 0 ff0 00000000 1 1 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 05 1 ff0 00000000 2 2 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 2 1 00 00 06 1 ef0 00000100 3 3 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 1 0 0 00 05 00 0 020 00000000 4 4 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 1 09 1 05 fffffff0 0 0 0 0
0 0 0 0 0 1 0 0 0 09 09 07 1 000 00000000 5 5 0 0 0 00 1 06 fffffff0 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 09 1 020 00000000 6 6 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 1 5 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 09 fffffff0 0 0 0 0
0 0 0 0 0 1 0 0 0 09 09 0a 1 030 00000000 7 7 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 0a fffffff0 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 0b 1 020 00000000 3 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 1f 1 020 00000000 5 1 1 2 0 00 0 00 00000000 0 0 0 0
0 0 1 4 8 1 0 0 0 00 00 0c 1 ff0 00000000 8 2 1 1 0 00 0 00 00000000 0 0 1 2
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 0b fffffff0 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 0c fffffff0 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 1e 1 020 00000000 2 3 0 0 0 00 0 00 00000000 0 0 0 0
0 0 1 7 7 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 1 0 1 00 00 00 0 7f0 00000000 9 4 1 3 0 00 0 00 00000000 0 0 0 0
0 0 1 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 0e 1 ff0 00000000 a 5 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 1 0 1 00 00 00 0 040 00000000 b 6 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 0f 1 040 00000000 c 7 0 0 0 00 0 00 00000000 0 0 0 0
1 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
1 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 0e fffffff0 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 0f 00000040 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 10 1 ff0 00000000 d 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 11 1 ff0 00000000 e 1 0 0 0 00 0 00 00000000 0 0 0 0
0 1 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 1 0 0 0 00 00 12 1 020 00000000 f 2 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 0 00 00000000 0 0 0 0
0 0 0 0 0 0 0 0 0 00 00 00 0 000 00000000 0 0 0 0 0 00 1 12 fffffff0 0 0 0 0
